// ==== verilog.f ====
+incdir+hdl
hdl/flash_bridge_pkg.sv
hdl/bus_cycle_ctrl.sv
hdl/flash_data_window.sv
hdl/flash_ctrl_regs.sv
hdl/flash_bridge_top.sv
tests/tb_clock_gen.sv
tests/flash_bridge_props.sv
tests/flash_bridge_tb.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the flash bridge regression with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f verilog.f \
	--top-module flash_bridge_tb -o sim_flash_bridge > build.log 2>&1 ||
	{ cat build.log; echo "Build error"; exit 1; }
./obj_dir/sim_flash_bridge > sim.log 2>&1 || { cat sim.log; echo "Simulation aborted"; exit 1; }
cat sim.log
grep -q "Regression failed" sim.log && exit 1 || exit 0

// ==== tests/flash_bridge_tb.sv ====
// Flash bridge testbench
`timescale 1ns/1ps
`default_nettype none

`include "flash_bridge_consts.svh"

module flash_bridge_tb import flash_bridge_pkg::*; ();

	localparam int TERM_EDGES = 4;	// Rising edges from strobe sample to terminate
	localparam int N_CYCLES = 10 + 48 + 36 + 16 + 30 + 40;
	localparam int WATCHDOG_PERIODS = N_CYCLES * 8 + 100;
	localparam bus_addr_t CTRL_ADDR = `FB_CTRL_BASE + `FB_CTRL_OFFSET;
	localparam bus_addr_t COUNT_ADDR = `FB_CTRL_BASE + `FB_COUNT_OFFSET;

	logic      CLK;
	logic      nRST;
	bus_addr_t addr;
	bus_data_t wdata;
	bus_data_t rdata;
	logic      rd_n;
	logic      wr;
	logic      term;

	int    seed = 32'hac74c8a3;
	int    checks = 0;
	int    tests = 0;
	int    errors = 0;
	int    test_errs = 0;
	string cur_test = "";

	// Reference model of the buffer and both control registers
	bus_data_t model_buf [`FB_WORDS];
	bus_data_t model_ctrl;
	bus_data_t model_count;

	tb_clock_gen u_tb_clock_gen (.CLK(CLK), .nRST(nRST));

	flash_bridge_top u_flash_bridge_top (.CLK(CLK), .nRST(nRST), .addr(addr), .wdata(wdata),
		.rd_n(rd_n), .wr(wr), .rdata(rdata), .term(term));

	function automatic bit in_data_win(bus_addr_t a);
		return a < `FB_DATA_BASE + (24'd1 << `FB_DATA_SPAN_BITS);
	endfunction

	function automatic bit in_ctrl_win(bus_addr_t a);
		return a >= `FB_CTRL_BASE && a < `FB_CTRL_BASE + 24'd8;
	endfunction

	function automatic bus_data_t model_read(bus_addr_t a);
		if (in_data_win(a))
			return model_buf[a[9:2]];	// Higher bits alias onto the same word
		if (in_ctrl_win(a))
			return (a - `FB_CTRL_BASE >= `FB_COUNT_OFFSET) ? model_count : model_ctrl;
		return '0;
	endfunction

	function automatic void model_write(bus_addr_t a, bus_data_t d);
		if (in_data_win(a)) begin
			if (!model_ctrl[`FB_CTRL_WP_BIT]) begin
				model_buf[a[9:2]] = d;
				model_count = model_count + 1;
			end
		end else if (in_ctrl_win(a) && a - `FB_CTRL_BASE < `FB_COUNT_OFFSET) begin
			model_ctrl = d;	// The counter offset is read-only
		end
	endfunction

	function automatic bus_addr_t rand_data_addr();
		bus_addr_t a;
		a = bus_addr_t'($random(seed));
		a[23:`FB_DATA_SPAN_BITS] = '0;
		return a;
	endfunction

	function automatic bus_addr_t rand_unmapped_addr();
		bus_addr_t a;
		do
			a = bus_addr_t'($random(seed));
		while (in_data_win(a) || in_ctrl_win(a));
		return a;
	endfunction

	task automatic check_word(string what, bus_data_t exp, bus_data_t act);
		checks++;
		assert (act === exp) else begin
			$display("ERR %s %s expected %h actual %h", cur_test, what, exp, act);
			test_errs++;
		end
	endtask

	task automatic check_true(bit ok, string msg);
		checks++;
		assert (ok) else begin
			$display("%s: %s", cur_test, msg);
			test_errs++;
		end
	endtask

	// One host cycle, with terminate timing checked on the falling edges
	task automatic bus_cycle(bit is_write, bus_addr_t a, bus_data_t d, int hold,
		output bus_data_t got);
		int edges;
		edges = 0;
		got = '0;
		@(posedge CLK);
		addr  <= a;
		wdata <= d;
		rd_n  <= is_write;
		wr    <= is_write;
		while (!term && edges < 16) begin
			@(negedge CLK);
			edges++;
		end
		if (!term) begin
			check_true(1'b0, $sformatf("term never rose for the cycle at %h", a));
		end else begin
			// The first negedge comes before the edge that samples the strobe
			check_word("term edges", TERM_EDGES, edges - 2);
			got = rdata;
			repeat (hold) begin
				@(negedge CLK);
				check_true(term, "term dropped while the strobe was held");
			end
		end
		@(posedge CLK);
		rd_n <= 1'b1;
		wr   <= 1'b0;
		@(negedge CLK);
		check_true(term, "term fell before the strobes were sampled idle");
		@(negedge CLK);
		check_true(!term, "term still high after the strobes were sampled idle");
	endtask

	task automatic host_access(bit is_write, bus_addr_t a, bus_data_t d, int hold = 0);
		bus_data_t got;
		bus_cycle(is_write, a, d, hold, got);
		if (is_write)
			model_write(a, d);
		else
			check_word($sformatf("read %h", a), model_read(a), got);
	endtask

	task automatic write_read(bus_addr_t wa, bus_addr_t ra);
		host_access(1'b1, wa, bus_data_t'($random(seed)));
		host_access(1'b0, ra, '0);
	endtask

	task automatic start_test(string name);
		cur_test = name;
		test_errs = 0;
	endtask

	task automatic end_test();
		$display("Test %s finished with %0d errors", cur_test, test_errs);
		errors += test_errs;
		tests++;
	endtask

	initial begin
		bus_addr_t a;
		bus_addr_t b;
		bit        is_write;
		int        region;
		addr  = '0;
		wdata = '0;
		rd_n  = 1'b1;
		wr    = 1'b0;
		for (int i = 0; i < `FB_WORDS; i++)
			model_buf[i] = '0;
		model_ctrl  = '0;
		model_count = '0;
		@(posedge nRST);
		@(negedge CLK);

		start_test("reset_values");
		check_true(!term, "term high after reset");
		repeat (8) host_access(1'b0, rand_data_addr(), '0);
		host_access(1'b0, CTRL_ADDR, '0);
		host_access(1'b0, COUNT_ADDR, '0);
		end_test();

		start_test("data_alias");
		repeat (24) begin
			a = rand_data_addr();
			b = rand_data_addr();
			b[9:2] = a[9:2];	// Same word, other high and byte bits
			write_read(a, b);
		end
		end_test();

		start_test("write_protect");
		host_access(1'b1, CTRL_ADDR, 32'h1 << `FB_CTRL_WP_BIT);
		repeat (8) begin
			a = rand_data_addr();
			write_read(a, a);
		end
		host_access(1'b0, COUNT_ADDR, '0);
		host_access(1'b1, CTRL_ADDR, '0);
		repeat (8) begin
			a = rand_data_addr();
			write_read(a, a);
		end
		host_access(1'b0, COUNT_ADDR, '0);
		end_test();

		start_test("ctrl_regs");
		repeat (6) write_read(CTRL_ADDR, CTRL_ADDR);
		repeat (2) write_read(COUNT_ADDR, COUNT_ADDR);
		end_test();

		start_test("unmapped");
		repeat (6) host_access(1'b0, rand_unmapped_addr(), '0);
		repeat (6) begin
			host_access(1'b1, rand_unmapped_addr(), bus_data_t'($random(seed)));
			host_access(1'b0, CTRL_ADDR, '0);
			host_access(1'b0, COUNT_ADDR, '0);
			host_access(1'b0, rand_data_addr(), '0);
		end
		end_test();

		start_test("random_mix");
		repeat (40) begin
			region = $random(seed) & 3;
			is_write = $random(seed) & 1;
			case (region)
				0: a = rand_data_addr();
				1: a = CTRL_ADDR;
				2: a = COUNT_ADDR;
				default: a = rand_unmapped_addr();
			endcase
			host_access(is_write, a, bus_data_t'($random(seed)), $random(seed) & 1);
		end
		end_test();

		$display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

	// Each host cycle takes about eight clock periods
	initial begin
		repeat (WATCHDOG_PERIODS) @(posedge CLK);
		$display("Watchdog expired after %0d clock periods", WATCHDOG_PERIODS);
		$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tests/flash_bridge_props.sv ====
// Bridge bus protocol assertions
`timescale 1ns/1ps
`default_nettype none

module flash_bridge_props (
	input wire CLK,
	input wire nRST,
	input wire rd_n,
	input wire wr,
	input wire term,
	input wire win_we,
	input wire regs_we
);

	// An edge that samples both strobes idle leaves terminate low
	term_idle_a: assert property (@(posedge CLK) disable iff (!nRST)
		(rd_n && !wr) |=> !term)
		else $error("term high after an edge that sampled both strobes idle");

	one_commit_a: assert property (@(posedge CLK) disable iff (!nRST)
		!(win_we && regs_we))
		else $error("window and register commits fired together");

	// A commit lasts one cycle and lines up with the rise of terminate
	commit_align_a: assert property (@(posedge CLK) disable iff (!nRST)
		(win_we || regs_we) |-> ($rose(term) && !$past(win_we || regs_we)))
		else $error("commit pulse not aligned with the rise of term");

endmodule

bind flash_bridge_top flash_bridge_props u_flash_bridge_props (
	.CLK     (CLK),
	.nRST    (nRST),
	.rd_n    (rd_n),
	.wr      (wr),
	.term    (term),
	.win_we  (win_we),
	.regs_we (regs_we)
);

`default_nettype wire

// ==== tests/tb_clock_gen.sv ====
// Testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
	output logic CLK,
	output logic nRST
);

	localparam int HALF_PERIOD = 10; // 20 ns clock

	initial begin
		CLK = 1'b0;
		forever #HALF_PERIOD CLK = ~CLK;
	end

	// Reset is held low across the first two rising edges
	initial begin
		nRST = 1'b0;
		repeat (2) @(posedge CLK);
		nRST <= 1'b1;
	end

endmodule

`default_nettype wire

// ==== hdl/flash_bridge_top.sv ====
// Flash register bridge top
`timescale 1ns/1ps
`default_nettype none

module flash_bridge_top import flash_bridge_pkg::*; (
	input  wire       CLK,
	input  wire       nRST,
	input  bus_addr_t addr,
	input  bus_data_t wdata,
	input  wire       rd_n,
	input  wire       wr,
	output bus_data_t rdata,
	output logic      term
);

	// Controller to the data window
	logic      win_we;
	word_idx_t win_idx;
	bus_data_t win_wdata;
	bus_data_t win_rdata;

	// Controller to the control registers
	logic      regs_we;
	logic      regs_sel;
	bus_data_t regs_wdata;
	bus_data_t regs_rdata;
	logic      wp;

	bus_cycle_ctrl u_bus_cycle_ctrl (
		.CLK        (CLK),
		.nRST       (nRST),
		.addr       (addr),
		.wdata      (wdata),
		.rd_n       (rd_n),
		.wr         (wr),
		.win_rdata  (win_rdata),
		.regs_rdata (regs_rdata),
		.wp         (wp),
		.term       (term),
		.rdata      (rdata),
		.win_we     (win_we),
		.win_idx    (win_idx),
		.win_wdata  (win_wdata),
		.regs_we    (regs_we),
		.regs_sel   (regs_sel),
		.regs_wdata (regs_wdata)
	);

	flash_data_window u_flash_data_window (
		.CLK   (CLK),
		.nRST  (nRST),
		.we    (win_we),
		.idx   (win_idx),
		.wdata (win_wdata),
		.rdata (win_rdata)
	);

	// The counter advances on every accepted data write
	flash_ctrl_regs u_flash_ctrl_regs (
		.CLK    (CLK),
		.nRST   (nRST),
		.we     (regs_we),
		.sel    (regs_sel),
		.wdata  (regs_wdata),
		.win_we (win_we),
		.rdata  (regs_rdata),
		.wp     (wp)
	);

endmodule

`default_nettype wire

// ==== hdl/flash_ctrl_regs.sv ====
// Flash control registers
`timescale 1ns/1ps
`default_nettype none

`include "flash_bridge_consts.svh"

module flash_ctrl_regs import flash_bridge_pkg::*; (
	input  wire       CLK,
	input  wire       nRST,
	input  wire       we,
	input  wire       sel,
	input  bus_data_t wdata,
	input  wire       win_we,
	output bus_data_t rdata,
	output logic      wp
);

	bus_data_t ctrl_word;
	bus_data_t write_count;

	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			ctrl_word   <= '0;
			write_count <= '0;
		end else begin
			// Host writes to the counter offset fall through here
			if (we && !sel)
				ctrl_word <= wdata;
			if (win_we)
				write_count <= write_count + 1'b1;	// Wraps at 2^32
		end
	end

	assign wp    = ctrl_word[`FB_CTRL_WP_BIT];
	assign rdata = sel ? write_count : ctrl_word;

endmodule

`default_nettype wire

// ==== hdl/flash_data_window.sv ====
// Flash data window buffer
`timescale 1ns/1ps
`default_nettype none

`include "flash_bridge_consts.svh"

module flash_data_window import flash_bridge_pkg::*; #(
	parameter int DEPTH = `FB_WORDS
) (
	input  wire       CLK,
	input  wire       nRST,
	input  wire       we,
	input  word_idx_t idx,
	input  bus_data_t wdata,
	output bus_data_t rdata
);

	// Stands in for the flash array, one word per index
	bus_data_t mem [DEPTH];

	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			for (int i = 0; i < DEPTH; i++)
				mem[i] <= '0;	// Buffer reads back zero after reset
		end else if (we) begin
			mem[idx] <= wdata;
		end
	end

	assign rdata = mem[idx]; // Read path has no clock

endmodule

`default_nettype wire

// ==== hdl/bus_cycle_ctrl.sv ====
// Host bus cycle controller
`timescale 1ns/1ps
`default_nettype none

`include "flash_bridge_consts.svh"

module bus_cycle_ctrl import flash_bridge_pkg::*; (
	input  wire       CLK,
	input  wire       nRST,
	input  bus_addr_t addr,
	input  bus_data_t wdata,
	input  wire       rd_n,
	input  wire       wr,
	input  bus_data_t win_rdata,
	input  bus_data_t regs_rdata,
	input  wire       wp,
	output logic      term,
	output bus_data_t rdata,
	output logic      win_we,
	output word_idx_t win_idx,
	output bus_data_t win_wdata,
	output logic      regs_we,
	output logic      regs_sel,
	output bus_data_t regs_wdata
);

	localparam int        SPAN       = `FB_DATA_SPAN_BITS;
	localparam bus_addr_t DATA_BASE  = `FB_DATA_BASE;
	localparam bus_addr_t CTRL_BASE  = `FB_CTRL_BASE;
	localparam logic [2:0] COUNT_OFS = `FB_COUNT_OFFSET;

	cycle_state_t state;
	wait_cnt_t    wait_cnt;
	logic         active;
	logic         in_data;
	logic         in_ctrl;
	logic [2:0]   ctrl_ofs;
	logic         last_wait;

	assign active = ~rd_n | wr; // Either strobe marks a cycle in flight

	// Byte offset bits are ignored since every access is a word
	assign in_data  = (addr[23:SPAN] == DATA_BASE[23:SPAN]);
	assign ctrl_ofs = {addr[2], 2'b00};
	assign in_ctrl  = (addr[23:3] == CTRL_BASE[23:3]);

	// The host holds addr until it sees term, so the index can follow it directly
	assign win_idx  = addr[9:2];	// Higher window bits alias onto the buffer
	assign regs_sel = (ctrl_ofs == COUNT_OFS);

	assign last_wait = (state == WAIT) && (wait_cnt == `FB_WAIT_STATES);

	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			state    <= IDLE;
			wait_cnt <= '0;
			term     <= 1'b0;
			win_we   <= 1'b0;
			regs_we  <= 1'b0;
			rdata    <= '0;
		end else begin
			win_we  <= 1'b0;	// Commit strobes last a single cycle
			regs_we <= 1'b0;
			case (state)
				IDLE: begin
					wait_cnt <= '0;
					if (active)
						state <= WAIT;
				end
				WAIT: begin
					if (!active) begin
						state <= IDLE;	// Strobe dropped early, abandon the cycle
					end else if (last_wait) begin
						state <= TERM;
						term  <= 1'b1;
						if (wr) begin
							win_we  <= in_data & ~wp;	// Protected writes are dropped
							regs_we <= in_ctrl;
						end else if (in_data) begin
							rdata <= win_rdata;
						end else if (in_ctrl) begin
							rdata <= regs_rdata;
						end else begin
							rdata <= '0;	// Unmapped read
						end
					end else begin
						wait_cnt <= wait_cnt + 1'b1;
					end
				end
				TERM, DONE: begin
					// Terminate stays up until the host releases both strobes
					if (!active) begin
						state <= IDLE;
						term  <= 1'b0;
					end else begin
						state <= DONE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Write data is captured on the terminate edge for the commit cycle
	always_ff @(posedge CLK) begin
		if (last_wait && wr) begin
			win_wdata  <= wdata;
			regs_wdata <= wdata;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/flash_bridge_pkg.sv ====
// Flash bridge types
`default_nettype none

package flash_bridge_pkg;

	// Host byte address
	typedef logic [23:0] bus_addr_t;

	// Host data word, always a full 32-bit access
	typedef logic [31:0] bus_data_t;

	typedef logic [7:0] word_idx_t; // Buffer word index from addr[9:2]

	typedef logic [2:0] wait_cnt_t; // Wait-state counter

	// Cycle controller states
	typedef enum logic [1:0] {
		IDLE,	// No cycle in flight
		WAIT,	// Counting wait states
		TERM,	// Commit cycle, terminate just raised
		DONE	// Holding terminate until the strobes drop
	} cycle_state_t;

endpackage

`default_nettype wire

// ==== hdl/flash_bridge_consts.svh ====
// Flash bridge constants
`ifndef FLASH_BRIDGE_CONSTS_SVH
`define FLASH_BRIDGE_CONSTS_SVH

// Data window, $000000 to $07FFFF
`define FB_DATA_BASE		24'h000000
`define FB_DATA_SPAN_BITS	19

// Control window, $080000 to $080007
`define FB_CTRL_BASE		24'h080000
`define FB_CTRL_OFFSET		3'd0	// Control word
`define FB_COUNT_OFFSET		3'd4	// Accepted-write counter

// Word buffer depth standing in for the flash part
`define FB_WORDS			256

// Terminate is raised when the wait counter reaches this value
`define FB_WAIT_STATES		3'd3

`define FB_CTRL_WP_BIT		0	// Write-protect bit of the control word

`endif
